// File: sim.f
hdl/tlp_chk_pkg.sv
hdl/beat_tracker.sv
hdl/hdr_decode.sv
hdl/tlp_rule_checker.sv
hdl/error_log.sv
hdl/tx_delay_gate.sv
hdl/afu_tx_checker.sv
bench/tb_clk_gen.sv
bench/afu_tx_checker_props.sv
bench/tb_afu_tx_checker.sv

// File: Bender.yml
package:
  name: afu_tx_checker

sources:
  - files:
      - hdl/tlp_chk_pkg.sv
      - hdl/beat_tracker.sv
      - hdl/hdr_decode.sv
      - hdl/tlp_rule_checker.sv
      - hdl/error_log.sv
      - hdl/tx_delay_gate.sv
      - hdl/afu_tx_checker.sv
  - target: simulation
    files:
      - bench/tb_clk_gen.sv
      - bench/afu_tx_checker_props.sv
      - bench/tb_afu_tx_checker.sv

// File: bench/tb_afu_tx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_afu_tx_checker;

   localparam int DATA_W         = 256;
   localparam int TIMEOUT_CYCLES = 2000;   // Sequence needs about 400 cycles

   logic                  clk;
   logic                  rst_n;
   logic                  tx_valid;
   logic                  tx_last;
   logic [DATA_W-1:0]     tx_data;
   logic                  clear_errors;
   logic                  out_valid;
   logic                  out_last;
   logic [DATA_W-1:0]     out_data;
   logic                  blocking;
   tlp_chk_pkg::t_err_vec err_vec;
   logic [63:0]           err_hdr;

   int          seed;
   int unsigned cycle_cnt = 0;
   logic [63:0] first_hdr;   // First offending header since the last clear
   logic [63:0] later_hdr;

   tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

   afu_tx_checker DUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .i_tx_valid     (tx_valid),
      .i_tx_last      (tx_last),
      .i_tx_data      (tx_data),
      .i_clear_errors (clear_errors),
      .o_tx_valid     (out_valid),
      .o_tx_last      (out_last),
      .o_tx_data      (out_data),
      .o_blocking     (blocking),
      .o_err_vec      (err_vec),
      .o_err_hdr      (err_hdr)
   );

   // ############################
   // Stimulus helpers
   // ############################

   function automatic logic [DATA_W-1:0] rand_beat();
      logic [DATA_W-1:0] v;
      for (int i = 0; i < DATA_W / 32; i++) begin
         v[i*32 +: 32] = $random(seed);
      end
      return v;
   endfunction

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         tx_valid <= 1'b0;
         tx_last  <= 1'b0;
      end
   endtask

   // Random gap of 0 to 2 idle cycles ahead of each beat
   task automatic send_beat(input logic last, input logic [DATA_W-1:0] data);
      idle($unsigned($random(seed)) % 3);
      @(posedge clk);
      tx_valid <= 1'b1;
      tx_last  <= last;
      tx_data  <= data;
   endtask

   task automatic send_packet(input logic [7:0] fmt, input logic [9:0] len_dw,
                              input logic [7:0] tag, input int n_payload,
                              output logic [63:0] hdr);
      logic [DATA_W-1:0] beat;
      hdr        = {32'($random(seed)), fmt, tag, 6'b0, len_dw};
      beat       = rand_beat();
      beat[63:0] = hdr;
      send_beat(n_payload == 0, beat);
      for (int i = 1; i <= n_payload; i++) begin
         send_beat(i == n_payload, rand_beat());
      end
   endtask

   task automatic send_clean_mix();
      logic [63:0] h;
      send_packet(tlp_chk_pkg::MEM_RD, 10'd32, 8'd5, 0, h);
      send_packet(tlp_chk_pkg::MEM_WR, 10'd64, 8'd0, 8, h);
      send_packet(tlp_chk_pkg::CPL, 10'd1, 8'd0, 0, h);
      send_packet(tlp_chk_pkg::CPLD, 10'd16, 8'd0, 2, h);
      send_packet(tlp_chk_pkg::MEM_WR, 10'd128, 8'd0, 16, h);   // Exactly 512 bytes
      send_packet(tlp_chk_pkg::MEM_RD, 10'd128, 8'd95, 0, h);   // Highest legal tag
      send_packet(tlp_chk_pkg::CPLD, 10'd3, 8'd0, 1, h);
   endtask

   task automatic pulse_clear();
      @(posedge clk);
      tx_valid     <= 1'b0;
      tx_last      <= 1'b0;
      clear_errors <= 1'b1;
      @(posedge clk);
      clear_errors <= 1'b0;
   endtask

   // ############################
   // Checks
   // ############################

   task automatic fail_run();
      $display("Test failed");
      $fatal(1);
   endtask

   // Sampled on the falling edge
   task automatic check_log(input logic [63:0] exp_hdr, input logic exp_blocking);
      @(negedge clk);
      if (blocking !== exp_blocking) begin
         $display("error: o_blocking = 0x%0h, expected 0x%0h", blocking, exp_blocking);
         fail_run();
      end
      if (exp_blocking && (err_hdr !== exp_hdr)) begin
         $display("error: o_err_hdr = 0x%016h, expected 0x%016h", err_hdr, exp_hdr);
         fail_run();
      end
      if (!exp_blocking && (err_vec !== '0)) begin
         $display("error: o_err_vec = 0x%02h, expected 0x00", err_vec);
         fail_run();
      end
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (DUT.u_props.assert_fails != 0) begin
         $display("A bound assertion on the DUT failed");
         fail_run();
      end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
         fail_run();
      end
   end

   // ############################
   // Test sequence
   // ############################

   initial begin
      seed         = 32'ha73e1dab;
      tx_valid     = 1'b0;
      tx_last      = 1'b0;
      tx_data      = '0;
      clear_errors = 1'b0;
      wait (rst_n === 1'b1);
      idle(2);

      send_clean_mix();
      idle(6);
      check_log('0, 1'b0);

      // 160 DW write is 640 bytes
      send_packet(tlp_chk_pkg::MEM_WR, 10'd160, 8'd0, 20, first_hdr);
      idle(6);
      check_log(first_hdr, 1'b1);

      // 1024-byte read on top leaves the first header in place
      send_packet(tlp_chk_pkg::MEM_RD, 10'd256, 8'd3, 0, later_hdr);
      idle(6);
      check_log(first_hdr, 1'b1);
      pulse_clear();
      check_log('0, 1'b0);

      send_packet(tlp_chk_pkg::MEM_RD, 10'd8, 8'd100, 0, first_hdr);   // Tag out of range
      idle(6);
      check_log(first_hdr, 1'b1);
      pulse_clear();

      send_packet(8'hff, 10'd4, 8'd0, 0, first_hdr);
      idle(6);
      check_log(first_hdr, 1'b1);
      pulse_clear();

      // 64 DW needs 8 payload beats but the last comes on the 7th
      send_packet(tlp_chk_pkg::MEM_WR, 10'd64, 8'd0, 7, first_hdr);
      idle(6);
      check_log(first_hdr, 1'b1);
      pulse_clear();

      // 32 DW needs 4 payload beats and gets one extra
      send_packet(tlp_chk_pkg::CPLD, 10'd32, 8'd0, 5, first_hdr);
      idle(6);
      check_log(first_hdr, 1'b1);
      pulse_clear();
      check_log('0, 1'b0);

      send_clean_mix();
      idle(6);
      check_log('0, 1'b0);

      idle(4);
      if (DUT.u_props.assert_fails != 0) begin
         $display("Bound assertions failed %0d times", DUT.u_props.assert_fails);
         fail_run();
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule : tb_afu_tx_checker

`default_nettype wire

// File: bench/afu_tx_checker_props.sv
`timescale 1ns/1ps
`default_nettype none

module afu_tx_checker_props #(
   parameter int DATA_W          = 256,
   parameter int MAX_PLD_SIZE    = 512,
   parameter int MAX_RD_REQ_SIZE = 512,
   parameter int MAX_TAGS        = 96
) (
   input wire logic                  clk,
   input wire logic                  rst_n,
   input wire logic                  i_tx_valid,
   input wire logic                  i_tx_last,
   input wire logic [DATA_W-1:0]     i_tx_data,
   input wire logic                  i_clear_errors,
   input wire logic                  i_out_valid,
   input wire logic                  i_out_last,
   input wire logic [DATA_W-1:0]     i_out_data,
   input wire logic                  i_blocking,
   input wire tlp_chk_pkg::t_err_vec i_err_vec
);

   localparam int DW_PER_BEAT = DATA_W / 32;

   int unsigned           assert_fails = 0;
   logic [7:0]            fmt;
   logic [7:0]            tag;
   int                    len_dw;       // Zero field already expanded to 1024
   logic                  sop;
   logic                  sop_data;
   logic                  in_pkt;
   logic                  has_data_q;
   int                    exp_beats_q;  // Payload beats the header asks for
   int                    n_beats_q;    // Payload beats seen so far
   tlp_chk_pkg::t_err_vec exp_err;      // Errors this beat should raise

   // ############################
   // Reference packet model
   // ############################

   always_comb begin
      fmt      = i_tx_data[tlp_chk_pkg::FMT_LSB +: tlp_chk_pkg::FMT_W];
      tag      = i_tx_data[tlp_chk_pkg::TAG_LSB +: tlp_chk_pkg::TAG_W];
      len_dw   = int'(i_tx_data[tlp_chk_pkg::LEN_LSB +: tlp_chk_pkg::LEN_W]);
      len_dw   = (len_dw == 0) ? 1024 : len_dw;
      sop      = i_tx_valid && !in_pkt;
      sop_data = (fmt == tlp_chk_pkg::MEM_WR) || (fmt == tlp_chk_pkg::CPLD);
      exp_err  = '0;
      if (sop) begin
         exp_err.malformed   = !(fmt inside {tlp_chk_pkg::MEM_RD, tlp_chk_pkg::MEM_WR,
                                             tlp_chk_pkg::CPL, tlp_chk_pkg::CPLD});
         exp_err.max_payload = (fmt == tlp_chk_pkg::MEM_WR) && (len_dw * 4 > MAX_PLD_SIZE);
         exp_err.max_rd_req  = (fmt == tlp_chk_pkg::MEM_RD) && (len_dw * 4 > MAX_RD_REQ_SIZE);
         exp_err.max_tag     = (fmt == tlp_chk_pkg::MEM_RD) && (int'(tag) >= MAX_TAGS);
         exp_err.insufficient_data = sop_data && i_tx_last;   // Header alone
      end else if (i_tx_valid && has_data_q) begin
         exp_err.insufficient_data = i_tx_last && (n_beats_q + 1 < exp_beats_q);
         exp_err.payload_overrun   = !i_tx_last && (n_beats_q + 1 >= exp_beats_q);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt      <= 1'b0;
         has_data_q  <= 1'b0;
         exp_beats_q <= 0;
         n_beats_q   <= 0;
      end else if (i_tx_valid) begin
         in_pkt <= !i_tx_last;
         if (sop) begin
            has_data_q  <= sop_data;
            exp_beats_q <= (len_dw + DW_PER_BEAT - 1) / DW_PER_BEAT;
            n_beats_q   <= 0;
         end else begin
            n_beats_q <= n_beats_q + 1;
         end
      end
   end

   // ############################
   // Assertions
   // ############################

   a_reset_idle: assert property (@(posedge clk)
      !rst_n |=> !i_out_valid && !i_blocking && (i_err_vec == '0))
      else begin
         $error("outputs active after reset");
         assert_fails++;
      end

   a_forward: assert property (@(posedge clk) disable iff (!rst_n)
      $past(i_tx_valid, 3) && !i_blocking |-> i_out_valid &&
      (i_out_last == $past(i_tx_last, 3)) && (i_out_data == $past(i_tx_data, 3)))
      else begin
         $error("beat not forwarded unchanged after 3 cycles");
         assert_fails++;
      end

   a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
      i_out_valid |-> $past(i_tx_valid, 3) && !i_blocking)
      else begin
         $error("output beat without matching input beat");
         assert_fails++;
      end

   a_rule_hit: assert property (@(posedge clk) disable iff (!rst_n)
      exp_err != '0 |-> ##3 ((i_err_vec & $past(exp_err, 3)) == $past(exp_err, 3)))
      else begin
         $error("expected error bit not logged");
         assert_fails++;
      end

   a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
      (i_err_vec & ~$past(i_err_vec) & ~$past(exp_err, 3)) == '0)
      else begin
         $error("error bit set without a rule violation");
         assert_fails++;
      end

   a_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      !i_clear_errors |=> ((i_err_vec & $past(i_err_vec)) == $past(i_err_vec)))
      else begin
         $error("logged error bit dropped without clear");
         assert_fails++;
      end

   a_clear: assert property (@(posedge clk) disable iff (!rst_n)
      i_clear_errors && ($past(exp_err, 2) == '0) |=> (i_err_vec == '0) && !i_blocking)
      else begin
         $error("error log not empty after clear");
         assert_fails++;
      end

endmodule : afu_tx_checker_props

bind afu_tx_checker afu_tx_checker_props #(
   .DATA_W          (DATA_W),
   .MAX_PLD_SIZE    (MAX_PLD_SIZE),
   .MAX_RD_REQ_SIZE (MAX_RD_REQ_SIZE),
   .MAX_TAGS        (MAX_TAGS)
) u_props (
   .clk            (clk),
   .rst_n          (rst_n),
   .i_tx_valid     (i_tx_valid),
   .i_tx_last      (i_tx_last),
   .i_tx_data      (i_tx_data),
   .i_clear_errors (i_clear_errors),
   .i_out_valid    (o_tx_valid),
   .i_out_last     (o_tx_last),
   .i_out_data     (o_tx_data),
   .i_blocking     (o_blocking),
   .i_err_vec      (o_err_vec)
);

`default_nettype wire

// File: bench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 2
) (
   output logic o_clk,
   output logic o_rst_n
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   // Reset held low for RST_CYCLES rising edges
   initial begin
      o_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge o_clk);
      o_rst_n <= 1'b1;
   end

endmodule : tb_clk_gen

`default_nettype wire

// File: hdl/afu_tx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module afu_tx_checker #(
   parameter int DATA_W          = 256,
   parameter int MAX_PLD_SIZE    = 512,   // Bytes
   parameter int MAX_RD_REQ_SIZE = 512,   // Bytes
   parameter int MAX_TAGS        = 96
) (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire logic                          i_tx_valid,
   input  wire logic                          i_tx_last,
   input  wire logic [DATA_W-1:0]             i_tx_data,
   input  wire logic                          i_clear_errors,
   output logic                               o_tx_valid,
   output logic                               o_tx_last,
   output logic [DATA_W-1:0]                  o_tx_data,
   output logic                               o_blocking,
   output tlp_chk_pkg::t_err_vec              o_err_vec,
   output logic [tlp_chk_pkg::HDR_W-1:0]      o_err_hdr
);

   logic                          sop;
   logic                          short_beat;
   logic                          long_beat;
   logic                          hdr_valid;
   tlp_chk_pkg::t_fmt_type        fmt;
   logic [12:0]                   len_bytes;
   logic [tlp_chk_pkg::TAG_W-1:0] tag;
   logic [tlp_chk_pkg::HDR_W-1:0] hdr;
   tlp_chk_pkg::t_err_vec         err;
   logic [tlp_chk_pkg::HDR_W-1:0] err_hdr;

   // ############################
   // Checker pipeline
   // ############################

   beat_tracker #(.DATA_W(DATA_W)) u_beat_tracker (
      .clk      (clk),
      .rst_n    (rst_n),
      .i_valid  (i_tx_valid),
      .i_last   (i_tx_last),
      .i_len_dw (i_tx_data[tlp_chk_pkg::LEN_LSB +: tlp_chk_pkg::LEN_W]),
      .o_sop    (sop),
      .o_short  (short_beat),
      .o_long   (long_beat)
   );

   hdr_decode #(.DATA_W(DATA_W)) u_hdr_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .i_valid     (i_tx_valid),
      .i_sop       (sop),
      .i_data      (i_tx_data),
      .o_hdr_valid (hdr_valid),
      .o_fmt       (fmt),
      .o_len_bytes (len_bytes),
      .o_tag       (tag),
      .o_hdr       (hdr)
   );

   tlp_rule_checker #(
      .MAX_PLD_SIZE    (MAX_PLD_SIZE),
      .MAX_RD_REQ_SIZE (MAX_RD_REQ_SIZE),
      .MAX_TAGS        (MAX_TAGS)
   ) u_tlp_rule_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .i_hdr_valid (hdr_valid),
      .i_fmt       (fmt),
      .i_len_bytes (len_bytes),
      .i_tag       (tag),
      .i_hdr       (hdr),
      .i_short     (short_beat),
      .i_long      (long_beat),
      .o_err       (err),
      .o_err_hdr   (err_hdr)
   );

   error_log u_error_log (
      .clk            (clk),
      .rst_n          (rst_n),
      .i_err          (err),
      .i_err_hdr      (err_hdr),
      .i_clear_errors (i_clear_errors),
      .o_err_vec      (o_err_vec),
      .o_blocking     (o_blocking),
      .o_err_hdr      (o_err_hdr)
   );

   // Raw beats wait here while the checker decides
   tx_delay_gate #(.DATA_W(DATA_W)) u_tx_delay_gate (
      .clk        (clk),
      .rst_n      (rst_n),
      .i_valid    (i_tx_valid),
      .i_last     (i_tx_last),
      .i_data     (i_tx_data),
      .i_blocking (o_blocking),
      .o_valid    (o_tx_valid),
      .o_last     (o_tx_last),
      .o_data     (o_tx_data)
   );

endmodule : afu_tx_checker

`default_nettype wire

// File: hdl/tx_delay_gate.sv
`timescale 1ns/1ps
`default_nettype none

module tx_delay_gate #(
   parameter int DATA_W = 256
) (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              i_valid,
   input  wire logic              i_last,
   input  wire logic [DATA_W-1:0] i_data,
   input  wire logic              i_blocking,
   output logic                   o_valid,
   output logic                   o_last,
   output logic [DATA_W-1:0]      o_data
);

   localparam int L = tlp_chk_pkg::CHK_LATENCY;

   logic [L-1:0]      vld_q;         // Stage 0 is the newest beat
   logic [L-1:0]      last_q;
   logic [DATA_W-1:0] data_q [L];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[L-2:0], i_valid};
      end
   end

   // Beat payload follows its valid bit down the line
   always_ff @(posedge clk) begin
      last_q    <= {last_q[L-2:0], i_last};
      data_q[0] <= i_data;
      for (int i = 1; i < L; i++) begin
         data_q[i] <= data_q[i-1];
      end
   end

   assign o_valid = vld_q[L-1] & ~i_blocking;   // Drop beats while blocked
   assign o_last  = last_q[L-1];
   assign o_data  = data_q[L-1];

endmodule : tx_delay_gate

`default_nettype wire

// File: hdl/error_log.sv
`timescale 1ns/1ps
`default_nettype none

module error_log (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire tlp_chk_pkg::t_err_vec         i_err,
   input  wire logic [tlp_chk_pkg::HDR_W-1:0] i_err_hdr,
   input  wire logic                          i_clear_errors,
   output tlp_chk_pkg::t_err_vec              o_err_vec,
   output logic                               o_blocking,
   output logic [tlp_chk_pkg::HDR_W-1:0]      o_err_hdr
);

   logic log_empty;   // No error logged, or being cleared now
   logic hdr_load;

   assign log_empty = i_clear_errors | ~(|o_err_vec);
   assign hdr_load  = log_empty & (|i_err);

   // ############################
   // Sticky error vector
   // ############################

   // A new error on the clear cycle still lands in the log
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_err_vec <= '0;
      end else if (i_clear_errors) begin
         o_err_vec <= i_err;
      end else begin
         o_err_vec <= o_err_vec | i_err;
      end
   end

   // Any logged error stops traffic
   assign o_blocking = |o_err_vec;

   // ############################
   // First-error header
   // ############################

   // Later errors leave the captured header alone
   always_ff @(posedge clk) begin
      if (hdr_load) begin
         o_err_hdr <= i_err_hdr;
      end
   end

endmodule : error_log

`default_nettype wire

// File: hdl/tlp_rule_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tlp_rule_checker #(
   parameter int MAX_PLD_SIZE    = 512,   // Bytes
   parameter int MAX_RD_REQ_SIZE = 512,   // Bytes
   parameter int MAX_TAGS        = 96
) (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire logic                          i_hdr_valid,
   input  wire tlp_chk_pkg::t_fmt_type        i_fmt,
   input  wire logic [12:0]                   i_len_bytes,
   input  wire logic [tlp_chk_pkg::TAG_W-1:0] i_tag,
   input  wire logic [tlp_chk_pkg::HDR_W-1:0] i_hdr,
   input  wire logic                          i_short,
   input  wire logic                          i_long,
   output tlp_chk_pkg::t_err_vec              o_err,
   output logic [tlp_chk_pkg::HDR_W-1:0]      o_err_hdr
);

   tlp_chk_pkg::t_err_vec err_d;
   logic                  is_rd;
   logic                  is_wr;
   logic                  is_known;
   logic                  has_data;   // Formats that carry payload beats

   // ############################
   // Format classification
   // ############################

   always_comb begin
      is_rd    = (i_fmt == tlp_chk_pkg::MEM_RD);
      is_wr    = (i_fmt == tlp_chk_pkg::MEM_WR);
      is_known = i_fmt inside {tlp_chk_pkg::MEM_RD, tlp_chk_pkg::MEM_WR,
                               tlp_chk_pkg::CPL, tlp_chk_pkg::CPLD};
      has_data = is_wr | (i_fmt == tlp_chk_pkg::CPLD);
   end

   // ############################
   // Rule evaluation
   // ############################

   always_comb begin
      err_d = '0;

      // Header rules are checked once per packet
      if (i_hdr_valid) begin
         err_d.malformed   = ~is_known;
         err_d.max_payload = is_wr & (i_len_bytes > 13'(MAX_PLD_SIZE));
         err_d.max_rd_req  = is_rd & (i_len_bytes > 13'(MAX_RD_REQ_SIZE));
         err_d.max_tag     = is_rd & (i_tag >= tlp_chk_pkg::TAG_W'(MAX_TAGS));
      end

      // Framing mismatches only matter for data-carrying formats
      err_d.insufficient_data = has_data & i_short;
      err_d.payload_overrun   = has_data & i_long;
   end

   // ############################
   // Registered strobes
   // ############################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_err <= '0;
      end else begin
         o_err <= err_d;   // One-cycle strobes
      end
   end

   // Header that goes with the strobes
   always_ff @(posedge clk) begin
      if (|err_d) begin
         o_err_hdr <= i_hdr;
      end
   end

endmodule : tlp_rule_checker

`default_nettype wire

// File: hdl/hdr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module hdr_decode #(
   parameter int DATA_W = 256
) (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire logic                          i_valid,
   input  wire logic                          i_sop,
   input  wire logic [DATA_W-1:0]             i_data,
   output logic                               o_hdr_valid,
   output tlp_chk_pkg::t_fmt_type             o_fmt,
   output logic [12:0]                        o_len_bytes,
   output logic [tlp_chk_pkg::TAG_W-1:0]      o_tag,
   output logic [tlp_chk_pkg::HDR_W-1:0]      o_hdr
);

   logic [tlp_chk_pkg::HDR_W-1:0] hdr_word;
   logic [tlp_chk_pkg::LEN_W-1:0] len_dw;
   logic [tlp_chk_pkg::FMT_W-1:0] fmt_code;
   logic                          hdr_load;

   // Header sits in the low word of the first beat
   assign hdr_word = i_data[tlp_chk_pkg::HDR_W-1:0];
   assign len_dw   = hdr_word[tlp_chk_pkg::LEN_LSB +: tlp_chk_pkg::LEN_W];
   assign fmt_code = hdr_word[tlp_chk_pkg::FMT_LSB +: tlp_chk_pkg::FMT_W];
   assign hdr_load = i_valid & i_sop;

   // ############################
   // Header valid strobe
   // ############################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_hdr_valid <= 1'b0;
      end else begin
         o_hdr_valid <= hdr_load;
      end
   end

   // ############################
   // Decoded fields
   // ############################

   // Held until the next start of packet
   always_ff @(posedge clk) begin
      if (hdr_load) begin
         o_hdr <= hdr_word;
         o_fmt <= tlp_chk_pkg::t_fmt_type'(fmt_code);
         o_tag <= hdr_word[tlp_chk_pkg::TAG_LSB +: tlp_chk_pkg::TAG_W];
         // DW to bytes
         if (len_dw == '0) begin
            o_len_bytes <= 13'd4096;
         end else begin
            o_len_bytes <= {1'b0, len_dw, 2'b00};
         end
      end
   end

endmodule : hdr_decode

`default_nettype wire

// File: hdl/beat_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module beat_tracker #(
   parameter int DATA_W = 256
) (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire logic                          i_valid,
   input  wire logic                          i_last,
   input  wire logic [tlp_chk_pkg::LEN_W-1:0] i_len_dw,
   output logic                               o_sop,
   output logic                               o_short,
   output logic                               o_long
);

   localparam int DW_PER_BEAT = DATA_W / 32;
   localparam int CNT_W       = tlp_chk_pkg::LEN_W + 1;

   logic             in_prog;     // Between sop and last
   logic [CNT_W-1:0] remaining;   // Payload beats still expected
   logic [CNT_W-1:0] len_dw_full;
   logic [CNT_W-1:0] sop_beats;

   assign o_sop = i_valid & ~in_prog;

   // Zero length field encodes the full 1024 DW
   assign len_dw_full = (i_len_dw == '0) ? CNT_W'(1 << tlp_chk_pkg::LEN_W) : CNT_W'(i_len_dw);
   assign sop_beats   = CNT_W'((len_dw_full + DW_PER_BEAT - 1) / DW_PER_BEAT);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_prog   <= 1'b0;
         remaining <= '0;
         o_short   <= 1'b0;
         o_long    <= 1'b0;
      end else begin
         o_short <= 1'b0;
         o_long  <= 1'b0;
         if (i_valid) begin
            in_prog <= ~i_last;
            if (o_sop) begin
               remaining <= sop_beats;
               o_short   <= i_last;   // Header beat carries no payload
            end else begin
               remaining <= (remaining != '0) ? remaining - 1'b1 : '0;
               o_short   <= i_last & (remaining > CNT_W'(1));
               o_long    <= ~i_last & (remaining <= CNT_W'(1));
            end
         end
      end
   end

endmodule : beat_tracker

`default_nettype wire

// File: hdl/tlp_chk_pkg.sv
`default_nettype none

package tlp_chk_pkg;

   // ############################
   // Header word layout
   // ############################

   localparam int HDR_W   = 64;   // Low word of the start-of-packet beat
   localparam int FMT_LSB = 24;   // Format/type in bits 31:24
   localparam int FMT_W   = 8;
   localparam int LEN_LSB = 0;    // Length in DW where zero means 1024
   localparam int LEN_W   = 10;
   localparam int TAG_LSB = 16;   // Tag in bits 23:16
   localparam int TAG_W   = 8;

   // Cycles from input beat to output slot
   localparam int CHK_LATENCY = 3;

   // ############################
   // Format/type codes
   // ############################

   // Any code outside this list is treated as malformed
   typedef enum logic [FMT_W-1:0] {
      MEM_RD = 8'h20,   // 4DW memory read
      MEM_WR = 8'h60,   // 4DW memory write
      CPL    = 8'h0a,   // Completion without data
      CPLD   = 8'h4a    // Completion with data
   } t_fmt_type;

   // ############################
   // Error vector
   // ############################

   typedef struct packed {
      logic malformed;
      logic max_payload;
      logic max_rd_req;
      logic max_tag;
      logic insufficient_data;
      logic payload_overrun;
   } t_err_vec;

endpackage : tlp_chk_pkg

`default_nettype wire
